/* rtl/motorPwmPkg.sv */
`default_nettype none

package motorPwmPkg;

    // clock is 10 MHz, so one count is 100 ns
    localparam int PERIOD_W   = 12;
    localparam int POS_W      = 16;
    localparam int STEP_LEN_W = 8;
    // shortest on-time the gate driver can switch cleanly
    localparam int MIN_PULSE  = 32;
    localparam int STEP_COUNT = 12;

    typedef logic [3:0] stepIdxT;

    // broadcast from the step timer to every phase
    typedef struct packed {
        logic                periodStart;
        logic                stepFirst;
        logic                stepLast;
        stepIdxT             stepIdx;
        logic [PERIOD_W-1:0] periodLen;
    } timingT;

    typedef struct packed {
        logic [POS_W-1:0] duty;
        logic             enable;
    } phaseCfgT;

    typedef struct packed {
        logic [POS_W-1:0] lost;
        logic [POS_W-1:0] pending;
    } phaseStatT;

endpackage

`default_nettype wire

/* rtl/motorAxiPkg.sv */
`default_nettype none

package motorAxiPkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axiRespE;

    // master side of all five channels
    typedef struct packed {
        logic [ADDR_W-1:0]   awaddr;
        logic                awvalid;
        logic [DATA_W-1:0]   wdata;
        logic [DATA_W/8-1:0] wstrb;
        logic                wvalid;
        logic                bready;
        logic [ADDR_W-1:0]   araddr;
        logic                arvalid;
        logic                rready;
    } axiReqT;

    typedef struct packed {
        logic              awready;
        logic              wready;
        axiRespE           bresp;
        logic              bvalid;
        logic              arready;
        logic [DATA_W-1:0] rdata;
        axiRespE           rresp;
        logic              rvalid;
    } axiRspT;

    // LOST_x and STATUS are read only
    typedef enum logic [ADDR_W-1:0] {
        CTRL    = 8'h00,
        PERIOD  = 8'h04,
        STEPLEN = 8'h08,
        DUTY_A  = 8'h0C,
        DUTY_B  = 8'h10,
        DUTY_C  = 8'h14,
        LOST_A  = 8'h18,
        LOST_B  = 8'h1C,
        LOST_C  = 8'h20,
        STATUS  = 8'h24
    } regAddrE;

endpackage

`default_nettype wire

/* rtl/motorStepTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module motorStepTimer
    import motorPwmPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  enable,
    input  logic [PERIOD_W-1:0]   periodLen,
    input  logic [STEP_LEN_W-1:0] stepLen,
    output timingT                timing
);

    logic                  run;
    logic                  active;
    logic [PERIOD_W-1:0]   periodPos;
    logic [STEP_LEN_W-1:0] stepPos;
    stepIdxT               stepIdx;
    logic                  periodEnd;
    logic                  stepEnd;

    // run trails enable by one cycle so the first period opens after enable rises
    assign active    = run && enable;
    assign periodEnd = periodPos >= periodLen - PERIOD_W'(1);
    assign stepEnd   = stepPos >= stepLen - STEP_LEN_W'(1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            run       <= 1'b0;
            periodPos <= '0;
            stepPos   <= '0;
            stepIdx   <= '0;
        end else if (!enable) begin
            // restart from step 0 on the next enable
            run       <= 1'b0;
            periodPos <= '0;
            stepPos   <= '0;
            stepIdx   <= '0;
        end else begin
            run <= 1'b1;
            if (run) begin
                if (!periodEnd) begin
                    periodPos <= periodPos + 1'b1;
                end else begin
                    periodPos <= '0;
                    if (!stepEnd) begin
                        stepPos <= stepPos + 1'b1;
                    end else begin
                        stepPos <= '0;
                        stepIdx <= (stepIdx == stepIdxT'(STEP_COUNT - 1)) ? '0 : stepIdx + 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        timing.periodStart = active && (periodPos == '0);
        timing.stepFirst   = active && (periodPos == '0) && (stepPos == '0);
        timing.stepLast    = active && periodEnd && stepEnd;
        timing.stepIdx     = stepIdx;
        timing.periodLen   = periodLen;
    end

    // a step opens on a period boundary right after enable or the previous step
    assert property (@(posedge clk) disable iff (!rstN)
        timing.stepFirst |-> timing.periodStart && (!$past(active) || $past(timing.stepLast)));

    // the next step follows straight after the last one while still enabled
    assert property (@(posedge clk) disable iff (!rstN)
        timing.stepLast ##1 enable |-> timing.stepFirst);

endmodule

`default_nettype wire

/* rtl/motorPhasePwm.sv */
`timescale 1ns/1ps
`default_nettype none

module motorPhasePwm
    import motorPwmPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  timingT    timing,
    input  phaseCfgT  cfg,
    output phaseStatT stat,
    output logic      pwmHigh,
    output logic      pwmLow
);

    logic [POS_W-1:0]    remainder;
    logic [PERIOD_W-1:0] pulseCnt;
    logic [POS_W-1:0]    wantAcc;
    logic [POS_W-1:0]    realAcc;
    logic [POS_W-1:0]    lost;
    logic [POS_W:0]      sum;
    logic [POS_W:0]      carry;
    logic [POS_W-1:0]    cap;
    logic [POS_W-1:0]    relCnt;
    logic [POS_W-1:0]    realNow;
    logic                pulse;
    logic                highSide;

    // pending on-time for this period where a new step starts from nothing
    always_comb begin
        sum = {1'b0, cfg.duty} + (timing.stepFirst ? '0 : {1'b0, remainder});
        cap = POS_W'(timing.periodLen) - POS_W'(1);
        if (sum < (POS_W + 1)'(MIN_PULSE)) begin
            relCnt = '0;
        end else if (sum > {1'b0, cap}) begin
            relCnt = cap;
        end else begin
            relCnt = sum[POS_W-1:0];
        end
        carry = sum - {1'b0, relCnt};
    end

    assign pulse   = (pulseCnt != '0) && cfg.enable;
    // the last pulse of a step can still be high on stepLast
    assign realNow = realAcc + POS_W'(pulse);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            remainder <= '0;
            pulseCnt  <= '0;
            wantAcc   <= '0;
            realAcc   <= '0;
            lost      <= '0;
        end else if (!cfg.enable) begin
            remainder <= '0;
            pulseCnt  <= '0;
            wantAcc   <= '0;
            realAcc   <= '0;
            lost      <= '0;
        end else begin
            if (timing.periodStart) begin
                pulseCnt  <= relCnt[PERIOD_W-1:0];
                // saturate rather than wrap when the duty is far above the period
                remainder <= carry[POS_W] ? '1 : carry[POS_W-1:0];
            end else if (pulseCnt != '0) begin
                pulseCnt <= pulseCnt - 1'b1;
            end

            if (timing.stepFirst) begin
                wantAcc <= cfg.duty;
            end else if (timing.periodStart) begin
                wantAcc <= wantAcc + cfg.duty;
            end

            if (timing.stepFirst) begin
                realAcc <= '0;
            end else if (pulse) begin
                realAcc <= realAcc + 1'b1;
            end

            if (timing.stepLast) begin
                lost <= (wantAcc >= realNow) ? wantAcc - realNow : realNow - wantAcc;
            end
        end
    end

    // steps 0 to 5 drive the high-side switch and 6 to 11 the low-side one
    assign highSide = timing.stepIdx < stepIdxT'(STEP_COUNT / 2);
    assign pwmHigh  = pulse && highSide;
    assign pwmLow   = pulse && !highSide;

    assign stat = '{lost: lost, pending: remainder};

    // no gate turns on while or right after the other one is on
    assert property (@(posedge clk) disable iff (!rstN)
        !(pwmHigh && pwmLow) && !(pwmHigh && $past(pwmLow)) && !(pwmLow && $past(pwmHigh)));

    // the cap keeps every pulse inside its own period
    assert property (@(posedge clk) disable iff (!rstN)
        timing.periodStart |-> pulseCnt == '0);

endmodule

`default_nettype wire

/* rtl/motorRegFile.sv */
`timescale 1ns/1ps
`default_nettype none

module motorRegFile
    import motorPwmPkg::*;
    import motorAxiPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  axiReqT                axiReq,
    output axiRspT                axiRsp,
    output logic                  enable,
    output logic [PERIOD_W-1:0]   periodLen,
    output logic [STEP_LEN_W-1:0] stepLen,
    output phaseCfgT              cfgA,
    output phaseCfgT              cfgB,
    output phaseCfgT              cfgC,
    input  phaseStatT             statA,
    input  phaseStatT             statB,
    input  phaseStatT             statC,
    input  stepIdxT               stepIdx
);

    typedef enum logic [1:0] {WR_IDLE, WR_ACCEPT, WR_RESP} wrStateE;
    typedef enum logic [1:0] {RD_IDLE, RD_ACCEPT, RD_RESP} rdStateE;

    wrStateE           wrState;
    rdStateE           rdState;
    logic              awready;
    logic              wready;
    logic              bvalid;
    axiRespE           bresp;
    logic              arready;
    logic              rvalid;
    axiRespE           rresp;
    logic [DATA_W-1:0] rdata;
    logic [POS_W-1:0]  dutyA;
    logic [POS_W-1:0]  dutyB;
    logic [POS_W-1:0]  dutyC;
    logic [DATA_W:0]   wrCur;
    logic [DATA_W:0]   rdCur;
    logic [DATA_W-1:0] strbMask;
    logic [DATA_W-1:0] wrData;
    logic              wrOk;

    // top bit flags a mapped address
    function automatic logic [DATA_W:0] readReg(input logic [ADDR_W-1:0] addr);
        case (regAddrE'(addr))
            CTRL:    return {1'b1, DATA_W'(enable)};
            PERIOD:  return {1'b1, DATA_W'(periodLen)};
            STEPLEN: return {1'b1, DATA_W'(stepLen)};
            DUTY_A:  return {1'b1, DATA_W'(dutyA)};
            DUTY_B:  return {1'b1, DATA_W'(dutyB)};
            DUTY_C:  return {1'b1, DATA_W'(dutyC)};
            LOST_A:  return {1'b1, DATA_W'(statA.lost)};
            LOST_B:  return {1'b1, DATA_W'(statB.lost)};
            LOST_C:  return {1'b1, DATA_W'(statC.lost)};
            STATUS:  return {1'b1, DATA_W'(stepIdx)};
            default: return '0;
        endcase
    endfunction

    always_comb begin
        wrCur = readReg(axiReq.awaddr);
        rdCur = readReg(axiReq.araddr);
        for (int i = 0; i < DATA_W / 8; i++) begin
            strbMask[8*i +: 8] = {8{axiReq.wstrb[i]}};
        end
        // byte lanes without a strobe keep their old contents
        wrData = (wrCur[DATA_W-1:0] & ~strbMask) | (axiReq.wdata & strbMask);
        case (regAddrE'(axiReq.awaddr))
            CTRL, PERIOD, STEPLEN, DUTY_A, DUTY_B, DUTY_C: wrOk = 1'b1;
            default:                                       wrOk = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrState   <= WR_IDLE;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            bresp     <= OKAY;
            enable    <= 1'b0;
            periodLen <= 12'd256;
            stepLen   <= 8'd4;
            dutyA     <= '0;
            dutyB     <= '0;
            dutyC     <= '0;
        end else begin
            case (wrState)
                WR_IDLE: begin
                    // take address and data together only
                    if (axiReq.awvalid && axiReq.wvalid) begin
                        awready <= 1'b1;
                        wready  <= 1'b1;
                        wrState <= WR_ACCEPT;
                    end
                end
                WR_ACCEPT: begin
                    awready <= 1'b0;
                    wready  <= 1'b0;
                    bvalid  <= 1'b1;
                    bresp   <= wrOk ? OKAY : SLVERR;
                    wrState <= WR_RESP;
                    case (regAddrE'(axiReq.awaddr))
                        CTRL:    enable    <= wrData[0];
                        PERIOD:  periodLen <= wrData[PERIOD_W-1:0];
                        STEPLEN: stepLen   <= wrData[STEP_LEN_W-1:0];
                        DUTY_A:  dutyA     <= wrData[POS_W-1:0];
                        DUTY_B:  dutyB     <= wrData[POS_W-1:0];
                        DUTY_C:  dutyC     <= wrData[POS_W-1:0];
                        default: ;
                    endcase
                end
                WR_RESP: begin
                    if (axiReq.bready) begin
                        bvalid  <= 1'b0;
                        wrState <= WR_IDLE;
                    end
                end
                default: wrState <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdState <= RD_IDLE;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= OKAY;
        end else begin
            case (rdState)
                RD_IDLE: begin
                    if (axiReq.arvalid) begin
                        arready <= 1'b1;
                        rdState <= RD_ACCEPT;
                    end
                end
                RD_ACCEPT: begin
                    arready <= 1'b0;
                    rvalid  <= 1'b1;
                    rresp   <= rdCur[DATA_W] ? OKAY : SLVERR;
                    rdState <= RD_RESP;
                end
                RD_RESP: begin
                    if (axiReq.rready) begin
                        rvalid  <= 1'b0;
                        rdState <= RD_IDLE;
                    end
                end
                default: rdState <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdState == RD_ACCEPT) begin
            rdata <= rdCur[DATA_W-1:0];
        end
    end

    assign cfgA = '{duty: dutyA, enable: enable};
    assign cfgB = '{duty: dutyB, enable: enable};
    assign cfgC = '{duty: dutyC, enable: enable};

    assign axiRsp = '{
        awready: awready,
        wready:  wready,
        bresp:   bresp,
        bvalid:  bvalid,
        arready: arready,
        rdata:   rdata,
        rresp:   rresp,
        rvalid:  rvalid
    };

    // write response is held, unchanged, until the master takes it
    assert property (@(posedge clk) disable iff (!rstN)
        axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid && $stable(axiRsp.bresp));

    // same for read data
    assert property (@(posedge clk) disable iff (!rstN)
        axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid && $stable(axiRsp.rdata));

endmodule

`default_nettype wire

/* rtl/motorPwmTop.sv */
`timescale 1ns/1ps
`default_nettype none

module motorPwmTop
    import motorPwmPkg::*;
    import motorAxiPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  axiReqT     axiReq,
    output axiRspT     axiRsp,
    output logic [2:0] pwmHigh,
    output logic [2:0] pwmLow
);

    logic                  enable;
    logic [PERIOD_W-1:0]   periodLen;
    logic [STEP_LEN_W-1:0] stepLen;
    timingT                timing;
    phaseCfgT              cfg [3];
    phaseStatT             stat [3];

    motorRegFile i_motorRegFile (
        .clk       (clk),
        .rstN      (rstN),
        .axiReq    (axiReq),
        .axiRsp    (axiRsp),
        .enable    (enable),
        .periodLen (periodLen),
        .stepLen   (stepLen),
        .cfgA      (cfg[0]),
        .cfgB      (cfg[1]),
        .cfgC      (cfg[2]),
        .statA     (stat[0]),
        .statB     (stat[1]),
        .statC     (stat[2]),
        .stepIdx   (timing.stepIdx)
    );

    motorStepTimer i_motorStepTimer (
        .clk       (clk),
        .rstN      (rstN),
        .enable    (enable),
        .periodLen (periodLen),
        .stepLen   (stepLen),
        .timing    (timing)
    );

    // phase A, B, C on bits 0, 1, 2
    for (genvar i = 0; i < 3; i++) begin : g_phase
        motorPhasePwm i_motorPhasePwm (
            .clk     (clk),
            .rstN    (rstN),
            .timing  (timing),
            .cfg     (cfg[i]),
            .stat    (stat[i]),
            .pwmHigh (pwmHigh[i]),
            .pwmLow  (pwmLow[i])
        );
    end

endmodule

`default_nettype wire

/* test/motorPwmTb.sv */
`timescale 1ns/1ps
`default_nettype none

module motorPwmTb
    import motorPwmPkg::*;
    import motorAxiPkg::*;
();

    // run lengths in periods times period length, three short tests and one full cycle
    localparam int TEST_CYCLES    = 3 * 8 * 64 + 24 * 80;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 2000;

    logic       clk;
    logic       rstN;
    axiReqT     axiReq;
    axiRspT     axiRsp;
    logic [2:0] pwmHigh;
    logic [2:0] pwmLow;

    int cycles = 0;
    int errors = 0;
    int checks = 0;
    // configuration of the running test, used by the monitor
    int tbPeriod = 64;
    int tbStepLen = 4;
    int tbDuty [3] = '{0, 0, 0};
    int runStart = 0;
    int periodLimit = 0;
    int pulseCount [3] = '{0, 0, 0};
    int runLen [6] = '{default: 0};
    int firstEdge [6] = '{default: 0};

    motorPwmTop i_motorPwmTop (
        .clk     (clk),
        .rstN    (rstN),
        .axiReq  (axiReq),
        .axiRsp  (axiRsp),
        .pwmHigh (pwmHigh),
        .pwmLow  (pwmLow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    task automatic checkEq(input int actual, input int expected, input string what);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    // one phase over one step, the remainder restarts with every step
    function automatic int phaseModel(input int duty, input int perLen, input int stepLen,
                                      input int periodIdx, output int lostOut);
        int rem;
        int sum;
        int width;
        int delivered;
        int result;
        rem = 0;
        delivered = 0;
        result = 0;
        for (int k = 0; k < stepLen; k++) begin
            sum = rem + duty;
            if (sum < MIN_PULSE) begin
                width = 0;
            end else if (sum > perLen - 1) begin
                width = perLen - 1;
            end else begin
                width = sum;
            end
            rem = sum - width;
            delivered += width;
            if (k == periodIdx) begin
                result = width;
            end
        end
        lostOut = duty * stepLen - delivered;
        return result;
    endfunction

    task automatic axiWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            output axiRespE resp);
        @(posedge clk);
        axiReq.awaddr  <= addr;
        axiReq.awvalid <= 1'b1;
        axiReq.wdata   <= data;
        axiReq.wstrb   <= '1;
        axiReq.wvalid  <= 1'b1;
        axiReq.bready  <= 1'b1;
        do @(posedge clk); while (!axiRsp.awready);
        axiReq.awvalid <= 1'b0;
        axiReq.wvalid  <= 1'b0;
        do @(posedge clk); while (!axiRsp.bvalid);
        resp = axiRsp.bresp;
        axiReq.bready <= 1'b0;
    endtask

    task automatic axiRead(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output axiRespE resp);
        @(posedge clk);
        axiReq.araddr  <= addr;
        axiReq.arvalid <= 1'b1;
        axiReq.rready  <= 1'b1;
        do @(posedge clk); while (!axiRsp.arready);
        axiReq.arvalid <= 1'b0;
        do @(posedge clk); while (!axiRsp.rvalid);
        data = axiRsp.rdata;
        resp = axiRsp.rresp;
        axiReq.rready <= 1'b0;
    endtask

    task automatic readExpect(input logic [ADDR_W-1:0] addr, input int expected,
                              input string what);
        logic [DATA_W-1:0] data;
        axiRespE           resp;
        axiRead(addr, data, resp);
        checkEq(resp, OKAY, {what, " response"});
        checkEq(data, expected, what);
    endtask

    // a pulse first seen high at edge e started in period (e - runStart - 2) / tbPeriod
    task automatic measurePulse(input int phase, input int lowSide, input int startEdge,
                                input int width);
        int rel;
        int p;
        int step;
        int lostUnused;
        rel = startEdge - runStart - 2;
        p = rel / tbPeriod;
        if (rel >= 0 && p < periodLimit) begin
            step = (p / tbStepLen) % STEP_COUNT;
            checkEq(width, phaseModel(tbDuty[phase], tbPeriod, tbStepLen, p % tbStepLen,
                                      lostUnused), $sformatf("phase %0d width, period %0d",
                                      phase, p));
            checkEq(lowSide, int'(step >= STEP_COUNT / 2),
                    $sformatf("phase %0d gate side in step %0d", phase, step));
            pulseCount[phase]++;
        end
    endtask

    // monitor, lines 0 to 2 are high side, 3 to 5 low side
    always @(posedge clk) begin
        logic [5:0] lines;
        lines = {pwmLow, pwmHigh};
        checkEq(pwmHigh & pwmLow, 0, "high and low gate on together");
        for (int j = 0; j < 6; j++) begin
            if (lines[j]) begin
                if (runLen[j] == 0) begin
                    firstEdge[j] = cycles;
                end
                runLen[j]++;
            end else if (runLen[j] != 0) begin
                measurePulse(j % 3, j / 3, firstEdge[j], runLen[j]);
                runLen[j] = 0;
            end
        end
    end

    task automatic regTest();
        logic [ADDR_W-1:0] addrs [5];
        int                vals [5];
        axiRespE           resp;
        addrs = '{PERIOD, STEPLEN, DUTY_A, DUTY_B, DUTY_C};
        vals = '{100, 5, 11, 22, 33};
        axiWrite(CTRL, 1, resp);
        readExpect(CTRL, 1, "CTRL readback after set");
        axiWrite(CTRL, 0, resp);
        readExpect(CTRL, 0, "CTRL readback after clear");
        for (int i = 0; i < 5; i++) begin
            axiWrite(addrs[i], vals[i], resp);
            checkEq(resp, OKAY, $sformatf("write response at 0x%02h", addrs[i]));
            readExpect(addrs[i], vals[i], $sformatf("readback at 0x%02h", addrs[i]));
        end
        axiWrite(LOST_A, 32'h1234, resp);
        checkEq(resp, SLVERR, "write to LOST_A");
        axiWrite(8'h40, 32'h5a, resp);
        checkEq(resp, SLVERR, "write to unmapped address");
        for (int i = 0; i < 5; i++) begin
            readExpect(addrs[i], vals[i], $sformatf("map intact at 0x%02h", addrs[i]));
        end
        readExpect(LOST_A, 0, "LOST_A after rejected write");
        readExpect(STATUS, 0, "STATUS while disabled");
    endtask

    task automatic runTest(input int period, input int stepLen, input int dA, input int dB,
                           input int dC, input int nPeriods);
        axiRespE           resp;
        logic [DATA_W-1:0] data;
        int                lostExp;
        int                expCount;
        int                mid;
        tbPeriod = period;
        tbStepLen = stepLen;
        tbDuty = '{dA, dB, dC};
        axiWrite(PERIOD, period, resp);
        axiWrite(STEPLEN, stepLen, resp);
        axiWrite(DUTY_A, dA, resp);
        axiWrite(DUTY_B, dB, resp);
        axiWrite(DUTY_C, dC, resp);
        pulseCount = '{0, 0, 0};
        axiWrite(CTRL, 1, resp);
        runStart = cycles;
        periodLimit = nPeriods;
        // a fresh enable always opens at step 0
        readExpect(STATUS, 0, "step index after enable");
        mid = nPeriods / 2;
        while (cycles < runStart + mid * period + 2) @(posedge clk);
        axiRead(STATUS, data, resp);
        checkEq(data, (mid / stepLen) % STEP_COUNT, "step index mid run");
        while (cycles < runStart + nPeriods * period + 2) @(posedge clk);
        for (int i = 0; i < 3; i++) begin
            void'(phaseModel(tbDuty[i], period, stepLen, 0, lostExp));
            readExpect(8'(LOST_A) + 8'(4 * i), lostExp, $sformatf("LOST of phase %0d", i));
        end
        axiWrite(CTRL, 0, resp);
        checkEq({pwmHigh, pwmLow}, 0, "gates right after disable");
        periodLimit = 0;
        repeat (2 * period) begin
            @(posedge clk);
            checkEq({pwmHigh, pwmLow}, 0, "gates while disabled");
        end
        for (int i = 0; i < 3; i++) begin
            expCount = 0;
            for (int p = 0; p < nPeriods; p++) begin
                if (phaseModel(tbDuty[i], period, stepLen, p % stepLen, lostExp) > 0) begin
                    expCount++;
                end
            end
            checkEq(pulseCount[i], expCount, $sformatf("pulse count of phase %0d", i));
        end
    endtask

    initial begin
        int dutyRand [3];
        void'($urandom(69163));
        axiReq = '0;
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        regTest();
        // duties below the minimum pulse, released once the carry builds up
        runTest(64, 4, 12, 20, 40, 8);
        // duties above the period saturate and leave a shortfall
        runTest(64, 4, 100, 150, 70, 8);
        for (int i = 0; i < 3; i++) begin
            dutyRand[i] = $urandom % 80;
        end
        // 24 periods of 2 per step cover a whole electrical cycle
        runTest(80, 2, dutyRand[0], dutyRand[1], dutyRand[2], 24);
        runTest(64, 4, 12, 20, 40, 8);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* motorPwm.f */
rtl/motorPwmPkg.sv
rtl/motorAxiPkg.sv
rtl/motorStepTimer.sv
rtl/motorPhasePwm.sv
rtl/motorRegFile.sv
rtl/motorPwmTop.sv
test/motorPwmTb.sv

/* Makefile */
# Verilator flow for the motor PWM subsystem
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
SIM_TOP   ?= motorPwmTb
FILELIST  ?= motorPwm.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(SIM_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
